// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP ?= decodeTop_tb
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails on any error"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== build.f ====
+incdir+hdl
hdl/uop_pkg.sv
hdl/decode_pkg.sv
hdl/stage_if.sv
hdl/uopQueue.sv
hdl/idecoder.sv
hdl/decodeStage.sv
hdl/decodeTop.sv
testbench/tb_clock.sv
testbench/decodeTop_asserts.sv
testbench/decodeTop_tb.sv

// ==== hdl/decodeStage.sv ====
// ====================
// decode output register
// takes the decoder bundle on a queue transfer and holds it
// until dispatch accepts it
// ====================
`timescale 1ns/1ps
`default_nettype none

module decodeStage
(
	input  logic clk,
	input  logic reset,
	uopStream_if.sink up,
	input  decode_pkg::decodedUop decoded,
	decodedStream_if.source down
);

	logic validReg;
	decode_pkg::decodedUop bundleReg;

	// empty or draining this cycle
	assign up.ready = !validReg || down.ready;

	assign down.valid = validReg;
	assign down.bundle = bundleReg;

	always_ff @(posedge clk)
	begin
		if (reset)
			validReg <= 1'b0;
		else if (up.ready)
			validReg <= up.valid;
	end

	// payload only moves on a transfer, held under back-pressure
	always_ff @(posedge clk)
	begin
		if (up.valid && up.ready)
			bundleReg <= decoded;
	end

endmodule

`default_nettype wire

// ==== hdl/decodeTop.sv ====
// ====================
// decode stage top level
// queue, classifier and output register behind plain ports
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "uop_config.svh"

module decodeTop
(
	input  logic clk,
	input  logic reset,
	// from the front end
	input  logic inValid,
	output logic inReady,
	input  logic [`UOP_WIDTH-1:0] inInstr,
	input  logic inPredictTaken,
	// to dispatch
	output logic outValid,
	input  logic outReady,
	output decode_pkg::decodedUop outUop
);

	uopStream_if headIf();
	decodedStream_if outIf();

	decode_pkg::decodedUop decodedBundle;

	uopQueue queue
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.inPredictTaken(inPredictTaken),
		.head(headIf.source)
	);

	// classifies whatever sits at the queue head
	idecoder decoder
	(
		.instr(headIf.instr),
		.predictTaken(headIf.predictTaken),
		.uop(decodedBundle)
	);

	decodeStage stage
	(
		.clk(clk),
		.reset(reset),
		.up(headIf.sink),
		.decoded(decodedBundle),
		.down(outIf.source)
	);

	// output stream onto plain ports
	assign outValid = outIf.valid;
	assign outIf.ready = outReady;
	assign outUop = outIf.bundle;

endmodule

`default_nettype wire

// ==== hdl/decode_pkg.sv ====
// ====================
// decoded micro-op as handed to dispatch
// the bundle struct travels on the decoded stream interface
// ====================
`default_nettype none

`include "uop_config.svh"

package decode_pkg;

	// memory access size
	typedef enum logic [2:0]
	{
		BYTE = 3'd0,
		WYDE = 3'd1
	} memSize;

	// decoded bundle, 32 bits
	typedef struct packed
	{
		// unit class
		logic isAlu;
		logic isMem;
		logic isFcu;
		// per-op flags
		logic isCmp;
		logic isLoad;
		logic isStore;
		logic isSei;
		logic isJmp;
		// conditional branch, predictable
		logic isBranch;
		logic rfw;
		logic needSr;
		logic wrap;
		// from the front end, untouched
		logic predictTaken;
		memSize size;
		logic [`UOP_SRC1_HI-`UOP_SRC1_LO:0] src1;
		uop_pkg::regSel dst;
		uop_pkg::regSel src2;
		uop_pkg::opcode opc;
	} decodedUop;

endpackage

`default_nettype wire

// ==== hdl/idecoder.sv ====
// ====================
// micro-op classifier, purely combinational
// sorts one micro-op into unit class and flags for dispatch
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "uop_config.svh"

module idecoder
(
	input  logic [`UOP_WIDTH-1:0] instr,
	input  logic predictTaken,
	output decode_pkg::decodedUop uop
);

	uop_pkg::opcode opc;
	uop_pkg::regSel dst;

	// only the opcode field selects the class, jump included
	assign opc = uop_pkg::opcode'(instr[`UOP_OPC_HI:`UOP_OPC_LO]);
	assign dst = uop_pkg::regSel'(instr[`UOP_DST_HI:`UOP_DST_LO]);

	always_comb
	begin
		// undefined codes fall through with every flag clear
		uop = '0;
		uop.size = decode_pkg::BYTE;
		// ====================
		// copied fields
		uop.opc = opc;
		uop.src1 = instr[`UOP_SRC1_HI:`UOP_SRC1_LO];
		uop.dst = dst;
		uop.src2 = uop_pkg::regSel'(instr[`UOP_SRC2_HI:`UOP_SRC2_LO]);
		uop.predictTaken = predictTaken;
		// ====================
		// classification
		case (opc)
		// no register result
		uop_pkg::LDIB, uop_pkg::BITB, uop_pkg::SEC, uop_pkg::CLC,
		uop_pkg::CLI, uop_pkg::CLV:
			uop.isAlu = 1'b1;
		uop_pkg::CMPB:
		begin
			uop.isAlu = 1'b1;
			uop.isCmp = 1'b1;
		end
		uop_pkg::SEI:
		begin
			uop.isAlu = 1'b1;
			uop.isSei = 1'b1;
		end
		uop_pkg::ADDW, uop_pkg::ADDB, uop_pkg::ANDB, uop_pkg::ORB,
		uop_pkg::EORB, uop_pkg::ASLB, uop_pkg::LSRB, uop_pkg::MOV:
		begin
			uop.isAlu = 1'b1;
			uop.rfw = 1'b1;
		end
		// carry in, so status register is a source
		uop_pkg::ADCB, uop_pkg::SBCB, uop_pkg::RORB, uop_pkg::ROLB:
		begin
			uop.isAlu = 1'b1;
			uop.rfw = 1'b1;
			uop.needSr = 1'b1;
		end
		uop_pkg::LDB, uop_pkg::LDW, uop_pkg::LDBW, uop_pkg::LDWW:
		begin
			uop.isMem = 1'b1;
			uop.isLoad = 1'b1;
			uop.rfw = 1'b1;
		end
		uop_pkg::STB, uop_pkg::STW, uop_pkg::STBW, uop_pkg::STWW:
		begin
			uop.isMem = 1'b1;
			uop.isStore = 1'b1;
		end
		// conditional branches read the flags
		uop_pkg::BEQ, uop_pkg::BNE, uop_pkg::BCS, uop_pkg::BCC,
		uop_pkg::BVS, uop_pkg::BVC, uop_pkg::BMI, uop_pkg::BPL:
		begin
			uop.isFcu = 1'b1;
			uop.isBranch = 1'b1;
			uop.needSr = 1'b1;
		end
		uop_pkg::JSI:
			uop.isFcu = 1'b1;
		uop_pkg::JMP:
		begin
			uop.isFcu = 1'b1;
			uop.isJmp = 1'b1;
		end
		default:
			uop.isAlu = 1'b0;
		endcase
		// ====================
		// memory forms, size and page wrap
		case (opc)
		uop_pkg::LDW, uop_pkg::STW:
			uop.size = decode_pkg::WYDE;
		uop_pkg::LDWW, uop_pkg::STWW:
		begin
			uop.size = decode_pkg::WYDE;
			uop.wrap = 1'b1;
		end
		uop_pkg::LDBW:
			uop.wrap = 1'b1;
		// byte store of SR needs the live status value
		uop_pkg::STB:
			uop.needSr = (dst == uop_pkg::SR);
		uop_pkg::STBW:
		begin
			uop.wrap = 1'b1;
			uop.needSr = (dst == uop_pkg::SR);
		end
		default:
			uop.wrap = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/stage_if.sv ====
// ====================
// valid/ready links between the decode blocks
// one carries raw micro-ops, the other decoded bundles
// transfer when valid and ready are both high
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "uop_config.svh"

// ====================
// raw micro-op stream
interface uopStream_if;

	logic valid;
	logic ready;
	logic [`UOP_WIDTH-1:0] instr;
	logic predictTaken;

	// producer side, valid and payload held until taken
	modport source (output valid, output instr, output predictTaken, input ready);

	// consumer side
	modport sink (input valid, input instr, input predictTaken, output ready);

endinterface

// ====================
// decoded bundle stream
interface decodedStream_if;

	logic valid;
	logic ready;
	decode_pkg::decodedUop bundle;

	modport source (output valid, output bundle, input ready);

	modport sink (input valid, input bundle, output ready);

endinterface

`default_nettype wire

// ==== hdl/uopQueue.sv ====
// ====================
// input queue for micro-ops from the front end
// circular buffer, head presented on a valid/ready stream
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "uop_config.svh"

module uopQueue
(
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	output logic inReady,
	input  logic [`UOP_WIDTH-1:0] inInstr,
	input  logic inPredictTaken,
	uopStream_if.source head
);

	localparam int addrBits = $clog2(`UOP_QUEUE_DEPTH);

	// payload storage, word and prediction bit per entry
	logic [`UOP_WIDTH-1:0] instrMem [`UOP_QUEUE_DEPTH];
	logic predMem [`UOP_QUEUE_DEPTH];

	logic [addrBits-1:0] wrPtr;
	logic [addrBits-1:0] rdPtr;
	// occupancy, one bit wider than the pointers
	logic [addrBits:0] count;
	logic push;
	logic pop;

	// full blocks the push even when a pop happens in the same cycle
	assign inReady = (count != (addrBits+1)'(`UOP_QUEUE_DEPTH));
	assign push = inValid && inReady;
	assign pop = head.valid && head.ready;

	// head of queue
	assign head.valid = (count != '0);
	assign head.instr = instrMem[rdPtr];
	assign head.predictTaken = predMem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			instrMem[wrPtr] <= inInstr;
			predMem[wrPtr] <= inPredictTaken;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
			2'b10:	count <= count + 1'b1;
			2'b01:	count <= count - 1'b1;
			default:	count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uop_config.svh ====
// ====================
// sizes and field positions of the micro-op word
// include in any file that slices a micro-op or sizes the queue
// ====================
`ifndef UOP_CONFIG_SVH
`define UOP_CONFIG_SVH

// micro-op word
`define UOP_WIDTH 16

// opcode field
`define UOP_OPC_HI 15
`define UOP_OPC_LO 10

// first source, four bits wide
`define UOP_SRC1_HI 9
`define UOP_SRC1_LO 6

// destination register select
`define UOP_DST_HI 5
`define UOP_DST_LO 3

// second source register select
`define UOP_SRC2_HI 2
`define UOP_SRC2_LO 0

// entries in the input queue, must be a power of two
`define UOP_QUEUE_DEPTH 4

`endif

// ==== hdl/uop_pkg.sv ====
// ====================
// micro-op encoding, opcodes and register selects
// referenced by scoped name from the decoder and its bundle
// ====================
`default_nettype none

`include "uop_config.svh"

package uop_pkg;

	// ====================
	// opcodes, one code per micro-op
	// codes not listed here are undefined
	typedef enum logic [`UOP_OPC_HI-`UOP_OPC_LO:0]
	{
		// alu group
		LDIB = 6'h00, ADDW = 6'h01, ADDB = 6'h02, ADCB = 6'h03,
		SBCB = 6'h04, CMPB = 6'h05, ANDB = 6'h06, BITB = 6'h07,
		ORB  = 6'h08, EORB = 6'h09, ASLB = 6'h0A, LSRB = 6'h0B,
		RORB = 6'h0C, ROLB = 6'h0D, MOV  = 6'h0E,
		// status flag group
		SEC  = 6'h10, CLC  = 6'h11, SEI  = 6'h12, CLI  = 6'h13,
		CLV  = 6'h14,
		// memory group, W suffix forms wrap within the page
		LDB  = 6'h18, LDW  = 6'h19, STB  = 6'h1A, STW  = 6'h1B,
		LDBW = 6'h1C, LDWW = 6'h1D, STBW = 6'h1E, STWW = 6'h1F,
		// flow control group
		BEQ  = 6'h20, BNE  = 6'h21, BCS  = 6'h22, BCC  = 6'h23,
		BVS  = 6'h24, BVC  = 6'h25, BMI  = 6'h26, BPL  = 6'h27,
		JSI  = 6'h28, JMP  = 6'h29
	} opcode;

	// ====================
	// register names for the dst and src2 fields
	typedef enum logic [`UOP_DST_HI-`UOP_DST_LO:0]
	{
		RA  = 3'd0,
		RX  = 3'd1,
		RY  = 3'd2,
		RSP = 3'd3,
		RT0 = 3'd4,
		RT1 = 3'd5,
		RT2 = 3'd6,
		// status register
		SR  = 3'd7
	} regSel;

endpackage

`default_nettype wire

// ==== testbench/decodeTop_asserts.sv ====
// ====================
// handshake and bundle checks on the decode output register
// bound into every decodeStage instance
// ====================
`timescale 1ns/1ps
`default_nettype none

module decodeTop_asserts
(
	input  logic clk,
	input  logic reset,
	input  logic valid,
	input  logic ready,
	input  decode_pkg::decodedUop bundle
);

	// stalled output keeps valid and payload
	holdUnderStall: assert property (@(posedge clk) disable iff (reset)
		valid && !ready |=> valid && $stable(bundle))
		else $error("output bundle changed or dropped while stalled");

	// register comes out of reset empty
	emptyAfterReset: assert property (@(posedge clk) reset |=> !valid)
		else $error("output valid right after reset");

	// loads and stores belong to the memory unit
	memClass: assert property (@(posedge clk) disable iff (reset)
		valid && (bundle.isLoad || bundle.isStore) |-> bundle.isMem)
		else $error("load or store without memory unit class");

	branchClass: assert property (@(posedge clk) disable iff (reset)
		valid && bundle.isBranch |-> bundle.isFcu)
		else $error("branch without flow control unit class");

endmodule

// attach to every decode output register
bind decodeStage decodeTop_asserts stageChecks
(
	.clk(clk),
	.reset(reset),
	.valid(validReg),
	.ready(down.ready),
	.bundle(bundleReg)
);

`default_nettype wire

// ==== testbench/decodeTop_tb.sv ====
// ====================
// directed tests for the decode stage top level
// a posedge monitor scores every output against a reference model
// inputs change on the falling edge only
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "uop_config.svh"

module decodeTop_tb;

	localparam int testCount = 6;
	localparam int clockPeriodNs = 40;
	localparam int watchdogNs = testCount * 200 * clockPeriodNs;
	localparam int queueDepth = `UOP_QUEUE_DEPTH;
	localparam int burstLength = 100;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	logic [`UOP_WIDTH-1:0] inInstr;
	logic inPredictTaken;
	logic outValid;
	logic outReady;
	decode_pkg::decodedUop outUop;

	integer seed = 32805;
	logic doneSending;
	// scoreboard queue with the oldest accepted micro-op first
	decode_pkg::decodedUop expected[$];

	tb_clock clockGen
	(
		.clk(clk)
	);

	decodeTop uut
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.inPredictTaken(inPredictTaken),
		.outValid(outValid),
		.outReady(outReady),
		.outUop(outUop)
	);

	// ====================
	// reporting and compare tasks
	task automatic stopRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkUop(input string what, input decode_pkg::decodedUop actual,
		input decode_pkg::decodedUop want);
		string field;
		if (actual !== want)
		begin
			field = "register fields";
			if (actual.opc !== want.opc)
				field = "opc";
			else if ({actual.isAlu, actual.isMem, actual.isFcu} !==
				{want.isAlu, want.isMem, want.isFcu})
				field = "unit class";
			else if ({actual.isCmp, actual.isLoad, actual.isStore, actual.isSei,
				actual.isJmp, actual.isBranch} !== {want.isCmp, want.isLoad,
				want.isStore, want.isSei, want.isJmp, want.isBranch})
				field = "op flags";
			else if (actual.rfw !== want.rfw)
				field = "rfw";
			else if (actual.needSr !== want.needSr)
				field = "needSr";
			else if (actual.wrap !== want.wrap)
				field = "wrap";
			else if (actual.size !== want.size)
				field = "size";
			else if (actual.predictTaken !== want.predictTaken)
				field = "predictTaken";
			stopRun($sformatf("ERR %0t ns: %s %s mismatch, got %h expected %h",
				$time, what, field, actual, want));
		end
	endtask

	task automatic checkHandshake(input string what, input logic actual, input logic want);
		if (actual !== want)
			stopRun($sformatf("ERR %0t ns: %s is %b, expected %b", $time, what, actual, want));
	endtask

	// ====================
	// reference classification
	function automatic decode_pkg::decodedUop expectUop(input logic [`UOP_WIDTH-1:0] instr,
		input logic pt);
		decode_pkg::decodedUop e;
		uop_pkg::opcode op;
		logic aluOp;
		logic flagOp;
		logic loadOp;
		logic storeOp;
		logic branchOp;
		op = uop_pkg::opcode'(instr[`UOP_OPC_HI:`UOP_OPC_LO]);
		aluOp = op inside {uop_pkg::LDIB, uop_pkg::ADDW, uop_pkg::ADDB, uop_pkg::ADCB,
			uop_pkg::SBCB, uop_pkg::CMPB, uop_pkg::ANDB, uop_pkg::BITB, uop_pkg::ORB,
			uop_pkg::EORB, uop_pkg::ASLB, uop_pkg::LSRB, uop_pkg::RORB, uop_pkg::ROLB,
			uop_pkg::MOV};
		flagOp = op inside {uop_pkg::SEC, uop_pkg::CLC, uop_pkg::SEI, uop_pkg::CLI,
			uop_pkg::CLV};
		loadOp = op inside {uop_pkg::LDB, uop_pkg::LDW, uop_pkg::LDBW, uop_pkg::LDWW};
		storeOp = op inside {uop_pkg::STB, uop_pkg::STW, uop_pkg::STBW, uop_pkg::STWW};
		branchOp = op inside {uop_pkg::BEQ, uop_pkg::BNE, uop_pkg::BCS, uop_pkg::BCC,
			uop_pkg::BVS, uop_pkg::BVC, uop_pkg::BMI, uop_pkg::BPL};
		e = '0;
		e.isAlu = aluOp || flagOp;
		e.isMem = loadOp || storeOp;
		e.isFcu = branchOp || (op inside {uop_pkg::JSI, uop_pkg::JMP});
		e.isBranch = branchOp;
		e.isCmp = (op == uop_pkg::CMPB);
		e.isSei = (op == uop_pkg::SEI);
		e.isJmp = (op == uop_pkg::JMP);
		e.isLoad = loadOp;
		e.isStore = storeOp;
		// compare, bit test and immediate load leave the register file alone
		e.rfw = loadOp || (aluOp && !(op inside {uop_pkg::BITB, uop_pkg::CMPB, uop_pkg::LDIB}));
		e.size = (op inside {uop_pkg::LDW, uop_pkg::LDWW, uop_pkg::STW, uop_pkg::STWW}) ?
			decode_pkg::WYDE : decode_pkg::BYTE;
		e.wrap = op inside {uop_pkg::LDBW, uop_pkg::LDWW, uop_pkg::STBW, uop_pkg::STWW};
		e.needSr = branchOp ||
			(op inside {uop_pkg::ADCB, uop_pkg::SBCB, uop_pkg::ROLB, uop_pkg::RORB}) ||
			((op inside {uop_pkg::STB, uop_pkg::STBW}) &&
			(instr[`UOP_DST_HI:`UOP_DST_LO] == uop_pkg::SR));
		e.src1 = instr[`UOP_SRC1_HI:`UOP_SRC1_LO];
		e.dst = uop_pkg::regSel'(instr[`UOP_DST_HI:`UOP_DST_LO]);
		e.src2 = uop_pkg::regSel'(instr[`UOP_SRC2_HI:`UOP_SRC2_LO]);
		e.opc = op;
		e.predictTaken = pt;
		return e;
	endfunction

	function automatic logic [31:0] randomWord();
		randomWord = $random(seed);
	endfunction

	// ====================
	// stimulus helpers
	// hold the word until the queue takes it
	task automatic sendUop(input logic [`UOP_WIDTH-1:0] word, input logic pt);
		@(negedge clk);
		inValid = 1'b1;
		inInstr = word;
		inPredictTaken = pt;
		while (!inReady)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic idle();
		@(negedge clk);
		inValid = 1'b0;
	endtask

	// open the output and wait for every pending bundle
	task automatic waitDrain();
		idle();
		outReady = 1'b1;
		while (expected.size() != 0)
			@(negedge clk);
		checkHandshake("outValid after drain", outValid, 1'b0);
	endtask

	// ====================
	// directed tests
	task automatic checkResetState();
		checkHandshake("outValid after reset", outValid, 1'b0);
		checkHandshake("inReady after reset", inReady, 1'b1);
	endtask

	task automatic runAllOpcodes();
		uop_pkg::opcode op;
		outReady = 1'b1;
		op = op.first();
		do
		begin
			sendUop({op, 4'd5, uop_pkg::RX, uop_pkg::RY}, 1'b0);
			op = op.next();
		end
		while (op != op.first());
		waitDrain();
	endtask

	task automatic runStatusNeeds();
		int d;
		// byte store only needs SR when it stores SR
		for (d = 0; d < 8; d++)
			sendUop({uop_pkg::STB, 4'd3, 3'(d), uop_pkg::RA}, 1'b0);
		sendUop({uop_pkg::STBW, 4'd3, uop_pkg::SR, uop_pkg::RA}, 1'b1);
		sendUop({uop_pkg::ADCB, 4'd1, uop_pkg::RA, uop_pkg::RX}, 1'b0);
		sendUop({uop_pkg::RORB, 4'd2, uop_pkg::RY, uop_pkg::RY}, 1'b0);
		sendUop({uop_pkg::BMI, 4'd0, uop_pkg::RA, uop_pkg::RA}, 1'b1);
		// undefined code classifies as nothing
		sendUop({6'h3F, 4'd0, uop_pkg::SR, uop_pkg::RA}, 1'b0);
		waitDrain();
	endtask

	task automatic runRandomFields();
		logic [31:0] r;
		repeat (20)
		begin
			r = randomWord();
			sendUop(r[`UOP_WIDTH-1:0], r[24]);
		end
		waitDrain();
	endtask

	task automatic runBackPressure();
		logic [31:0] r;
		int accepted;
		accepted = 0;
		@(negedge clk);
		outReady = 1'b0;
		repeat (queueDepth + 4)
		begin
			// room in the queue plus the one output register
			checkHandshake("inReady under stall", inReady, accepted < queueDepth + 1);
			// inReady seen here decides the coming edge
			if (inReady)
			begin
				r = randomWord();
				inValid = 1'b1;
				inInstr = r[`UOP_WIDTH-1:0];
				inPredictTaken = r[16];
				accepted++;
			end
			@(negedge clk);
		end
		inValid = 1'b0;
		checkHandshake("inReady when full", inReady, 1'b0);
		repeat (4)
		begin
			@(negedge clk);
			checkHandshake("outValid under stall", outValid, 1'b1);
			// oldest accepted micro-op stays in the output register
			checkUop("held", outUop, expected[0]);
		end
		waitDrain();
	endtask

	task automatic runRandomStalls();
		logic [`UOP_WIDTH-1:0] words[burstLength];
		logic preds[burstLength];
		logic [31:0] r;
		logic [31:0] stall;
		int i;
		int j;
		for (i = 0; i < burstLength; i++)
		begin
			r = randomWord();
			words[i] = r[`UOP_WIDTH-1:0];
			preds[i] = r[20];
		end
		doneSending = 1'b0;
		fork
			begin
				for (j = 0; j < burstLength; j++)
					sendUop(words[j], preds[j]);
				idle();
				doneSending = 1'b1;
			end
			begin
				while (!doneSending)
				begin
					@(negedge clk);
					stall = randomWord();
					outReady = stall[0];
				end
			end
		join
		waitDrain();
	endtask

	// ====================
	// scoreboard monitor sampling on the edge where transfers happen
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (outValid && outReady)
			begin
				if (expected.size() == 0)
					stopRun("a bundle left the DUT with no accepted micro-op pending");
				else
					checkUop("output", outUop, expected.pop_front());
			end
			if (inValid && inReady)
				expected.push_back(expectUop(inInstr, inPredictTaken));
		end
	end

	// watchdog with a budget of 200 cycles per test
	initial
	begin
		#(watchdogNs);
		stopRun("timeout: the tests did not finish within the cycle budget");
	end

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		inPredictTaken = 1'b0;
		outReady = 1'b0;
		doneSending = 1'b0;
		repeat (10)
			@(negedge clk);
		reset = 1'b0;
		checkResetState();
		runAllOpcodes();
		runStatusNeeds();
		runRandomFields();
		runBackPressure();
		runRandomStalls();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// ====================
// free-running testbench clock, 40 ns period
// starts low at time zero
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic clk
);

	localparam int halfPeriodNs = 20;

	initial
	begin
		clk = 1'b0;
		forever
			#(halfPeriodNs) clk = ~clk;
	end

endmodule

`default_nettype wire
